// File: flist.f
+incdir+include
verilog/mcPkg.sv
verilog/stateSequencer.sv
verilog/microCodeController.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/multiCycleCore.sv
verif/tbClockGen.sv
verif/mc_assert.sv
verif/tbMultiCycleCore.sv

// File: Bender.yml
package:
  name: multi_cycle_core

export_include_dirs:
  - include

sources:
  - verilog/mcPkg.sv
  - verilog/stateSequencer.sv
  - verilog/microCodeController.sv
  - verilog/aluUnit.sv
  - verilog/regFile.sv
  - verilog/multiCycleCore.sv
  - target: simulation
    files:
      - verif/tbClockGen.sv
      - verif/mc_assert.sv
      - verif/tbMultiCycleCore.sv

// File: verif/tbMultiCycleCore.sv
`timescale 1ns/100ps
`include "mc_params.svh"

module tbMultiCycleCore;
        import mcPkg::*;

        typedef struct packed {
                logic [31:0] instr;
                retireInfo   exp;
                logic        skip;  // Jumped over, never retires
        } rowT;

        logic                clk;
        logic                rstN;
        logic [`MC_XLEN-1:0] memRdata;
        memReq               memBus;
        logic                retire;
        retireInfo           retireData;
        logic                halted;
        logic [`MC_XLEN-1:0] memArr [2**`MC_AW];
        rowT                 rows [$];
        string               names [$];
        logic [15:0]         lfsr;
        int                  errors = 0;
        int                  checks = 0;
        int                  cycles = 0;
        int                  limit = 1000;

        tbClockGen u_clk (.clk(clk), .rstN(rstN));

        multiCycleCore u_dut (
                .clk        (clk),
                .rstN       (rstN),
                .memRdata   (memRdata),
                .mem        (memBus),
                .retire     (retire),
                .retireData (retireData),
                .halted     (halted)
        );

        assign memRdata = memArr[memBus.addr];  // Same-cycle read

        always @(posedge clk) begin
                if (memBus.write) begin
                        memArr[memBus.addr] <= memBus.wdata;
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles == limit) begin
                        $display("timeout after %0d cycles, the core did not halt", cycles);
                        $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                                 u_dut.u_assert.fails);
                        $display("Checks failed");
                        $finish;
                end
        end

        // Galois LFSR, taps 16 14 13 11
        function automatic logic [11:0] randImm();
                logic [11:0] v;
                for (int i = 0; i < 12; i++) begin
                        v[i] = lfsr[0];
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
                end
                return v;
        endfunction

        function automatic logic [31:0] encR(input logic [2:0] f3, input logic f7b5,
                                             input logic [4:0] rd, rs1, rs2);
                return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, OP_ARITH};
        endfunction

        function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
                return {imm, rs1, f3, rd, op};
        endfunction

        task automatic addRow(input string name, input logic [31:0] instr,
                              input logic [4:0] rd, input logic [31:0] rdData,
                              input logic wr, input logic [31:0] nextPc, input logic skip);
                rowT r;
                r.instr = instr;
                r.exp   = {nextPc, rd, rdData, wr};
                r.skip  = skip;
                rows.push_back(r);
                names.push_back(name);
        endtask

        task automatic waitRetire();
                @(negedge clk);
                while (!retire) begin
                        @(negedge clk);
                end
        endtask

        initial begin
                logic [11:0] r1, r2, r3;
                logic [31:0] x1, x2, x3, lt, x15;
                retireInfo   got;
                lfsr = 16'd29141;
                r1 = randImm();
                r2 = randImm();
                r3 = randImm();
                x1 = {{20{r1[11]}}, r1};
                x2 = {{20{r2[11]}}, r2};
                x3 = x1 + x2;
                lt = ($signed(x1) < $signed(x2)) ? 32'd1 : 32'd0;
                x15 = x1 + {{20{r3[11]}}, r3};

                addRow("addi_x1", encI(r1, 0, 3'b000, 1, OP_ARITH_IMM), 1, x1, 1, 4, 0);
                addRow("addi_x2", encI(r2, 0, 3'b000, 2, OP_ARITH_IMM), 2, x2, 1, 8, 0);
                addRow("add", encR(3'b000, 0, 3, 1, 2), 3, x3, 1, 12, 0);
                addRow("sub", encR(3'b000, 1, 4, 1, 2), 4, x1 - x2, 1, 16, 0);
                addRow("and", encR(3'b111, 0, 5, 1, 2), 5, x1 & x2, 1, 20, 0);
                addRow("or", encR(3'b110, 0, 6, 1, 2), 6, x1 | x2, 1, 24, 0);
                addRow("slt", encR(3'b010, 0, 7, 1, 2), 7, lt, 1, 28, 0);
                addRow("addi_rnd", encI(r3, 1, 3'b000, 15, OP_ARITH_IMM), 15, x15, 1, 32, 0);
                addRow("base", encI(12'h100, 0, 3'b000, 8, OP_ARITH_IMM), 8, 256, 1, 36, 0);
                addRow("sw", 32'h0034_2023, 0, 0, 0, 40, 0);  // sw x3, 0(x8)
                addRow("lw", encI(12'd0, 8, 3'b010, 9, OP_LOAD), 9, x3, 1, 44, 0);
                addRow("beq_taken", 32'h0034_8463, 0, 0, 0, 52, 0);  // beq x9, x3, +8
                addRow("skip_a", encI(12'd1, 0, 3'b000, 10, OP_ARITH_IMM), 0, 0, 0, 0, 1);
                addRow("beq_not_taken", 32'h0004_0463, 0, 0, 0, 56, 0);  // beq x8, x0, +8
                addRow("jal", 32'h0080_05EF, 11, 60, 1, 64, 0);  // jal x11, +8
                addRow("skip_b", encI(12'd2, 0, 3'b000, 10, OP_ARITH_IMM), 0, 0, 0, 0, 1);
                addRow("addi_link", encI(12'd71, 0, 3'b000, 12, OP_ARITH_IMM), 12, 71, 1, 68, 0);
                // 71 + 6 = 77, bit 0 cleared
                addRow("jalr", encI(12'd6, 12, 3'b000, 13, OP_JALR), 13, 72, 1, 76, 0);
                addRow("skip_c", encI(12'd3, 0, 3'b000, 10, OP_ARITH_IMM), 0, 0, 0, 0, 1);
                addRow("jal_x0", 32'h0040_006F, 0, 80, 1, 80, 0);  // jal x0, +4
                addRow("add_x0", encR(3'b000, 0, 14, 0, 1), 14, x1, 1, 84, 0);
                addRow("ecall", 32'h0000_0073, 0, 0, 0, 88, 0);

                // Background pattern from the whole word address
                for (int i = 0; i < 2**`MC_AW; i++) begin
                        memArr[i] = 32'hC0DE_0000 ^ i;
                end
                foreach (rows[i]) begin
                        memArr[i] = rows[i].instr;
                end
                limit = rows.size() * 5 + 4 + 30;

                @(posedge rstN);
                foreach (rows[i]) begin
                        if (!rows[i].skip) begin
                                waitRetire();
                                got = retireData;
                                checks++;
                                assert (got == rows[i].exp) else begin
                                        errors++;
                                        $display("mismatch %s expected %h actual %h",
                                                 names[i], rows[i].exp, got);
                                end
                        end
                end

                repeat (8) begin
                        @(negedge clk);
                        checks++;
                        assert (halted && !retire && !memBus.read && !memBus.write) else begin
                                errors++;
                                $display("core not halted and quiet after ECALL");
                        end
                end
                checks++;
                assert (memArr[64] == x3) else begin  // Byte address 256
                        errors++;
                        $display("mismatch sw_mem expected %h actual %h", x3, memArr[64]);
                end

                $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                         u_dut.u_assert.fails);
                if (errors == 0 && u_dut.u_assert.fails == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

// File: verif/mc_assert.sv
`timescale 1ns/100ps

module mcAssert (
        input logic           clk,
        input logic           rstN,
        input mcPkg::cpuState state,
        input mcPkg::opcodeT  opcode,
        input mcPkg::ctrlWord ctrl
);
        import mcPkg::*;

        int fails = 0;  // Assertion failures so far

        memStrobeExcl: assert property (@(posedge clk) disable iff (!rstN)
                !(ctrl.memRead && ctrl.memWrite))
                else begin
                        fails++;
                        $error("memRead and memWrite asserted together");
                end

        regWriteInWb: assert property (@(posedge clk) disable iff (!rstN)
                ctrl.regWrite |-> state == WB)
                else begin
                        fails++;
                        $error("regWrite raised outside WB");
                end

        haltSticky: assert property (@(posedge clk) disable iff (!rstN)
                state == HALT |=> state == HALT)
                else begin
                        fails++;
                        $error("core left the HALT state");
                end

        // EX2 only follows EX1 of a BEQ
        ex2AfterBranch: assert property (@(posedge clk) disable iff (!rstN)
                state == EX2 |-> $past(state) == EX1 && $past(opcode) == OP_BRANCH)
                else begin
                        fails++;
                        $error("EX2 entered without a branch in EX1");
                end

endmodule

// Sequencer and controller signals as seen inside the core
bind multiCycleCore mcAssert u_assert (
        .clk    (clk),
        .rstN   (rstN),
        .state  (state),
        .opcode (opcode),
        .ctrl   (ctrl)
);

// File: verif/tbClockGen.sv
`timescale 1ns/100ps

module tbClockGen (
        output logic clk,
        output logic rstN
);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;  // 40 ns period
        end

        initial begin
                rstN = 1'b0;
                repeat (4) @(posedge clk);
                rstN <= 1'b1;
        end

endmodule

// File: verilog/multiCycleCore.sv
`timescale 1ns/100ps
`include "mc_params.svh"

module multiCycleCore (
        input  logic                clk,
        input  logic                rstN,
        input  logic [`MC_XLEN-1:0] memRdata,
        output mcPkg::memReq        mem,
        output logic                retire,
        output mcPkg::retireInfo    retireData,
        output logic                halted
);
        import mcPkg::*;

        localparam int RW = $clog2(`MC_NREG);

        logic [`MC_XLEN-1:0] pc;
        logic [`MC_XLEN-1:0] ir;
        logic [`MC_XLEN-1:0] mdr;
        logic [`MC_XLEN-1:0] a;
        logic [`MC_XLEN-1:0] b;
        logic [`MC_XLEN-1:0] aluOut;
        logic [`MC_XLEN-1:0] aluResult;
        logic [`MC_XLEN-1:0] rdata1;
        logic [`MC_XLEN-1:0] rdata2;
        logic [`MC_XLEN-1:0] immI;
        logic [`MC_XLEN-1:0] immS;
        logic [`MC_XLEN-1:0] immB;
        logic [`MC_XLEN-1:0] immJ;
        logic [`MC_XLEN-1:0] imm;
        logic [`MC_XLEN-1:0] opA;
        logic [`MC_XLEN-1:0] opB;
        logic [`MC_XLEN-1:0] pcNext;
        logic [`MC_XLEN-1:0] wbData;
        logic                zero;
        logic                pcEn;
        cpuState             state;
        opcodeT              opcode;
        ctrlWord             ctrl;

        assign opcode = opcodeT'(ir[6:0]);

        stateSequencer u_seq (
                .clk    (clk),
                .rstN   (rstN),
                .opcode (opcode),
                .zero   (zero),
                .state  (state)
        );

        microCodeController u_ctrl (
                .state  (state),
                .opcode (opcode),
                .ctrl   (ctrl)
        );

        assign immI = {{(`MC_XLEN-12){ir[31]}}, ir[31:20]};
        assign immS = {{(`MC_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
        assign immB = {{(`MC_XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
        assign immJ = {{(`MC_XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

        always_comb begin
                case (opcode)
                        OP_STORE:  imm = immS;
                        OP_BRANCH: imm = immB;
                        OP_JAL:    imm = immJ;
                        default:   imm = immI;
                endcase
        end

        assign opA = (ctrl.srcA == SRCA_A) ? a : pc;

        always_comb begin
                case (ctrl.srcB)
                        SRCB_FOUR: opB = `MC_XLEN'(4);
                        SRCB_IMM:  opB = imm;
                        default:   opB = b;
                endcase
        end

        aluUnit u_alu (
                .aluOp    (ctrl.aluOp),
                .funct3   (ir[14:12]),
                .funct7b5 (ir[30]),
                .isImm    (opcode == OP_ARITH_IMM),
                .opA      (opA),
                .opB      (opB),
                .result   (aluResult),
                .zero     (zero)
        );

        assign wbData = ctrl.memToReg ? mdr : aluOut;

        regFile u_rf (
                .clk    (clk),
                .rs1    (ir[19:15]),
                .rs2    (ir[24:20]),
                .rd     (ir[11:7]),
                .wdata  (wbData),
                .we     (ctrl.regWrite),
                .rdata1 (rdata1),
                .rdata2 (rdata2)
        );

        // Bit 0 cleared for JALR targets
        assign pcNext = ctrl.pcSource ? aluOut : {aluResult[`MC_XLEN-1:1], 1'b0};
        assign pcEn   = ctrl.pcWrite | (ctrl.pcWriteNotCond & ~zero);

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        pc <= '0;
                end else if (pcEn) begin
                        pc <= pcNext;
                end
        end

        always_ff @(posedge clk) begin
                if (ctrl.irWrite) begin
                        ir <= memRdata;
                end
                if (ctrl.memRead && ctrl.iOrD) begin
                        mdr <= memRdata;
                end
                a      <= rdata1;
                b      <= rdata2;
                aluOut <= aluResult;  // Loads every cycle
        end

        always_comb begin
                mem.addr  = ctrl.iOrD ? aluOut[`MC_AW+1:2] : pc[`MC_AW+1:2];
                mem.wdata = b;
                mem.read  = ctrl.memRead;
                mem.write = ctrl.memWrite;
        end

        // Every instruction ends on its PC write
        assign retire = pcEn;

        always_comb begin
                retireData.nextPc  = pcNext;
                retireData.rd      = ctrl.regWrite ? ir[11:7] : RW'(0);
                retireData.rdData  = ctrl.regWrite ? wbData : '0;
                retireData.rdWrite = ctrl.regWrite;
        end

        assign halted = (state == HALT);

endmodule

// File: verilog/regFile.sv
`timescale 1ns/100ps
`include "mc_params.svh"

module regFile (
        input  logic                        clk,
        input  logic [$clog2(`MC_NREG)-1:0] rs1,
        input  logic [$clog2(`MC_NREG)-1:0] rs2,
        input  logic [$clog2(`MC_NREG)-1:0] rd,
        input  logic [`MC_XLEN-1:0]         wdata,
        input  logic                        we,
        output logic [`MC_XLEN-1:0]         rdata1,
        output logic [`MC_XLEN-1:0]         rdata2
);

        logic [`MC_XLEN-1:0] regs [`MC_NREG];

        always_ff @(posedge clk) begin
                if (we && rd != '0) begin
                        regs[rd] <= wdata;
                end
        end

        // x0 reads as zero whatever the array holds
        assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
        assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/100ps
`include "mc_params.svh"

module aluUnit (
        input  mcPkg::aluOpT        aluOp,
        input  logic [2:0]          funct3,
        input  logic                funct7b5,
        input  logic                isImm,
        input  logic [`MC_XLEN-1:0] opA,
        input  logic [`MC_XLEN-1:0] opB,
        output logic [`MC_XLEN-1:0] result,
        output logic                zero
);
        import mcPkg::*;

        typedef enum logic [2:0] {
                FN_ADD,
                FN_SUB,
                FN_AND,
                FN_OR,
                FN_SLT
        } aluFn;

        aluFn fn;

        always_comb begin
                fn = FN_ADD;
                case (aluOp)
                        ALUOP_SUB: fn = FN_SUB;
                        ALUOP_FUNCT: begin
                                case (funct3)
                                        // ADDI has no funct7, its imm bits must not pick SUB
                                        3'b000: fn = (!isImm && funct7b5) ? FN_SUB : FN_ADD;
                                        3'b010: fn = FN_SLT;
                                        3'b110: fn = FN_OR;
                                        3'b111: fn = FN_AND;
                                        default: fn = FN_ADD;
                                endcase
                        end
                        default: fn = FN_ADD;
                endcase
        end

        always_comb begin
                case (fn)
                        FN_SUB: result = opA - opB;
                        FN_AND: result = opA & opB;
                        FN_OR:  result = opA | opB;
                        FN_SLT: begin
                                result = {{(`MC_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
                        end
                        default: result = opA + opB;
                endcase
        end

        assign zero = (result == '0);  // Drives BEQ sequencing

endmodule

// File: verilog/microCodeController.sv
`timescale 1ns/100ps

module microCodeController (
        input  mcPkg::cpuState state,
        input  mcPkg::opcodeT  opcode,
        output mcPkg::ctrlWord ctrl
);
        import mcPkg::*;

        always_comb begin
                ctrl.pcWrite        = 1'b0;
                ctrl.pcWriteNotCond = 1'b0;
                ctrl.iOrD           = 1'b0;
                ctrl.memRead        = 1'b0;
                ctrl.memWrite       = 1'b0;
                ctrl.memToReg       = 1'b0;
                ctrl.irWrite        = 1'b0;
                ctrl.pcSource       = 1'b0;
                ctrl.aluOp          = ALUOP_ADD;
                ctrl.srcA           = SRCA_PC;
                ctrl.srcB           = SRCB_B;
                ctrl.regWrite       = 1'b0;
                ctrl.isEcall        = 1'b0;

                case (state)
                        IF: begin
                                ctrl.memRead = 1'b1;
                                ctrl.irWrite = 1'b1;
                        end
                        ID: begin
                                // PC+4 lands in ALUOut
                                ctrl.srcB = SRCB_FOUR;
                                if (opcode == OP_ECALL) begin
                                        ctrl.isEcall = 1'b1;
                                        ctrl.pcWrite = 1'b1;
                                end
                        end
                        EX1: begin
                                case (opcode)
                                        OP_ARITH: begin
                                                ctrl.srcA  = SRCA_A;
                                                ctrl.aluOp = ALUOP_FUNCT;
                                        end
                                        OP_ARITH_IMM: begin
                                                ctrl.srcA  = SRCA_A;
                                                ctrl.srcB  = SRCB_IMM;
                                                ctrl.aluOp = ALUOP_FUNCT;
                                        end
                                        OP_LOAD,
                                        OP_STORE: begin
                                                ctrl.srcA = SRCA_A;  // Effective address
                                                ctrl.srcB = SRCB_IMM;
                                        end
                                        OP_BRANCH: begin
                                                ctrl.srcA           = SRCA_A;
                                                ctrl.aluOp          = ALUOP_SUB;
                                                ctrl.pcWriteNotCond = 1'b1;
                                                ctrl.pcSource       = 1'b1;
                                        end
                                        default: begin
                                                // JAL, JALR and anything unknown
                                                ctrl.srcB = SRCB_FOUR;
                                        end
                                endcase
                        end
                        EX2: begin
                                if (opcode == OP_BRANCH) begin
                                        ctrl.srcB    = SRCB_IMM;  // Branch target
                                        ctrl.pcWrite = 1'b1;
                                end
                        end
                        MEM: begin
                                ctrl.iOrD = 1'b1;
                                if (opcode == OP_LOAD) begin
                                        ctrl.memRead = 1'b1;
                                end else begin
                                        ctrl.memWrite = 1'b1;
                                        ctrl.srcB     = SRCB_FOUR;
                                        ctrl.pcWrite  = 1'b1;
                                end
                        end
                        WB: begin
                                case (opcode)
                                        OP_ARITH,
                                        OP_ARITH_IMM: begin
                                                ctrl.regWrite = 1'b1;
                                                ctrl.srcB     = SRCB_FOUR;
                                                ctrl.pcWrite  = 1'b1;
                                        end
                                        OP_LOAD: begin
                                                ctrl.regWrite = 1'b1;
                                                ctrl.memToReg = 1'b1;  // Write MDR
                                                ctrl.srcB     = SRCB_FOUR;
                                                ctrl.pcWrite  = 1'b1;
                                        end
                                        OP_JAL: begin
                                                ctrl.regWrite = 1'b1;
                                                ctrl.srcB     = SRCB_IMM;
                                                ctrl.pcWrite  = 1'b1;
                                        end
                                        OP_JALR: begin
                                                ctrl.regWrite = 1'b1;
                                                ctrl.srcA     = SRCA_A;
                                                ctrl.srcB     = SRCB_IMM;
                                                ctrl.pcWrite  = 1'b1;
                                        end
                                        default: begin
                                                ctrl.regWrite = 1'b0;
                                        end
                                endcase
                        end
                        default: begin
                                // HALT keeps every strobe low
                                ctrl.pcWrite = 1'b0;
                        end
                endcase
        end

endmodule

// File: verilog/stateSequencer.sv
`timescale 1ns/100ps

module stateSequencer (
        input  logic           clk,
        input  logic           rstN,
        input  mcPkg::opcodeT  opcode,
        input  logic           zero,
        output mcPkg::cpuState state
);
        import mcPkg::*;

        cpuState nextState;

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        state <= IF;
                end else begin
                        state <= nextState;
                end
        end

        always_comb begin
                nextState = state;
                case (state)
                        IF: nextState = ID;
                        ID: nextState = (opcode == OP_ECALL) ? HALT : EX1;
                        EX1: begin
                                case (opcode)
                                        // Not taken ends here, taken adds EX2
                                        OP_BRANCH: nextState = zero ? EX2 : IF;
                                        OP_LOAD,
                                        OP_STORE: nextState = MEM;
                                        default: nextState = WB;
                                endcase
                        end
                        EX2: nextState = IF;
                        MEM: begin
                                if (opcode == OP_LOAD) begin
                                        nextState = WB;
                                end else begin
                                        nextState = IF;  // Store done
                                end
                        end
                        WB: nextState = IF;
                        HALT: nextState = HALT;
                        default: nextState = IF;
                endcase
        end

endmodule

// File: verilog/mcPkg.sv
`include "mc_params.svh"

package mcPkg;

        typedef enum logic [2:0] {
                IF,
                ID,
                EX1,
                EX2,
                MEM,
                WB,
                HALT
        } cpuState;

        // RV32 major opcodes of the supported subset
        typedef enum logic [6:0] {
                OP_ARITH     = 7'b0110011,
                OP_ARITH_IMM = 7'b0010011,
                OP_LOAD      = 7'b0000011,
                OP_STORE     = 7'b0100011,
                OP_BRANCH    = 7'b1100011,
                OP_JAL       = 7'b1101111,
                OP_JALR      = 7'b1100111,
                OP_ECALL     = 7'b1110011
        } opcodeT;

        typedef enum logic {SRCA_PC, SRCA_A} srcASel;

        typedef enum logic [1:0] {SRCB_B, SRCB_FOUR, SRCB_IMM} srcBSel;

        typedef enum logic [1:0] {ALUOP_ADD, ALUOP_SUB, ALUOP_FUNCT} aluOpT;

        typedef struct packed {
                logic   pcWrite;
                logic   pcWriteNotCond;
                logic   iOrD;           // 1 selects ALUOut as data address
                logic   memRead;
                logic   memWrite;
                logic   memToReg;
                logic   irWrite;
                logic   pcSource;       // 0 ALU result, 1 ALUOut
                aluOpT  aluOp;
                srcASel srcA;
                srcBSel srcB;
                logic   regWrite;
                logic   isEcall;
        } ctrlWord;

        typedef struct packed {
                logic [`MC_AW-1:0]   addr;
                logic [`MC_XLEN-1:0] wdata;
                logic                read;
                logic                write;
        } memReq;

        typedef struct packed {
                logic [`MC_XLEN-1:0]         nextPc;
                logic [$clog2(`MC_NREG)-1:0] rd;
                logic [`MC_XLEN-1:0]         rdData;
                logic                        rdWrite;
        } retireInfo;

endpackage

// File: include/mc_params.svh
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// Datapath and register width
`define MC_XLEN 32

// Word address width of the shared memory bus
// Byte address bits [MC_AW+1:2] reach the memory
`define MC_AW 10

// Architectural register count, x0 included
`define MC_NREG 32

`endif
